//--- hw/rob_conf_pkg.sv
package rob_conf_pkg;

  // ------------------------------------------------------------------------
  // dispatch side
  // ------------------------------------------------------------------------
  localparam int DISP_SIZE      = 4;    // slots per group

  // ------------------------------------------------------------------------
  // buffer geometry
  // ------------------------------------------------------------------------
  localparam int ROB_ENTRY_SIZE = 8;
  localparam int ROB_ENTRY_W    = $clog2(ROB_ENTRY_SIZE);

  // entry index plus one lap bit, so full and empty differ
  localparam int CMT_ID_W       = ROB_ENTRY_W + 1;

  // ------------------------------------------------------------------------
  // completion side
  // ------------------------------------------------------------------------
  localparam int DONE_BUS_SIZE  = 2;    // report ports per cycle

  // datapath width of pc and tval
  localparam int XLEN           = 32;

endpackage

//--- hw/rob_pkg.sv
package rob_pkg;

  typedef logic [rob_conf_pkg::CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [rob_conf_pkg::DISP_SIZE-1:0] grp_id_t;   // one bit per slot
  typedef logic [rob_conf_pkg::XLEN-1:0]      xlen_t;

  // mcause values
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN = 4'd0,
    INST_ACC_FAULT     = 4'd1,
    ILLEGAL_INST       = 4'd2,
    BREAKPOINT         = 4'd3,
    LOAD_ACC_FAULT     = 4'd5,
    STORE_ACC_FAULT    = 4'd7,
    ECALL_U            = 4'd8,
    ECALL_S            = 4'd9,
    ECALL_M            = 4'd11
  } except_t;

  typedef struct packed {
    logic    valid;
    grp_id_t grp_id;    // occupied slots
    xlen_t   pc;        // pc of slot 0
  } disp_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    grp_id_t grp_id;          // one-hot slot
    logic    br_upd;          // mispredicted branch
    logic    except_valid;
    except_t except_type;
    xlen_t   tval;
  } done_rpt_t;

  typedef struct packed {
    logic                                 valid;
    grp_id_t                              grp_id;
    grp_id_t                              done_grp_id;
    xlen_t                                pc;
    grp_id_t                              br_upd;
    grp_id_t                              except_valid;
    except_t [rob_conf_pkg::DISP_SIZE-1:0] except_type;
    xlen_t   [rob_conf_pkg::DISP_SIZE-1:0] tval;
  } rob_entry_t;

  typedef struct packed {
    logic    commit;
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    grp_id_t except_valid;    // one-hot
    except_t except_type;
    xlen_t   tval;
    xlen_t   epc;
    grp_id_t dead_id;
    logic    flush;
  } commit_t;

endpackage

//--- hw/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  logic             i_pop,
  input  logic             i_flush,
  output logic             o_disp_ready,
  output rob_pkg::cmt_id_t o_in_id,
  output rob_pkg::cmt_id_t o_out_id,
  output logic             o_load
);

  rob_pkg::cmt_id_t r_in_id;    // next id to hand out
  rob_pkg::cmt_id_t r_out_id;   // oldest id, head of buffer
  logic             w_full;

  // same slot, opposite lap
  assign w_full = (r_in_id[rob_conf_pkg::ROB_ENTRY_W-1:0] ==
                   r_out_id[rob_conf_pkg::ROB_ENTRY_W-1:0]) &
                  (r_in_id[rob_conf_pkg::ROB_ENTRY_W] != r_out_id[rob_conf_pkg::ROB_ENTRY_W]);

  // dispatch is dropped while a redirect commits
  assign o_disp_ready = ~w_full & ~i_flush;
  assign o_load       = i_disp_valid & o_disp_ready;

  assign o_in_id  = r_in_id;
  assign o_out_id = r_out_id;

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_in_id  <= '0;
      r_out_id <= '0;
    end else if (i_flush) begin
      // restart both just after the committing group
      r_in_id  <= r_out_id + 1'b1;
      r_out_id <= r_out_id + 1'b1;
    end else begin
      if (o_load) begin
        r_in_id <= r_in_id + 1'b1;
      end
      if (i_pop) begin
        r_out_id <= r_out_id + 1'b1;
      end
    end
  end

endmodule

//--- hw/rob_entry.sv
`timescale 1ns/1ps

module rob_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_load,
  input  rob_pkg::disp_t      i_disp,
  input  rob_pkg::done_rpt_t  i_done_rpt [rob_conf_pkg::DONE_BUS_SIZE],
  input  logic                i_retire,
  input  logic                i_flush,
  output rob_pkg::rob_entry_t o_entry,
  output logic                o_all_done
);

  logic                                     r_valid;
  rob_pkg::grp_id_t                         r_grp_id;
  rob_pkg::grp_id_t                         r_done_grp_id;
  rob_pkg::grp_id_t                         r_br_upd;
  rob_pkg::grp_id_t                         r_except_valid;
  rob_pkg::xlen_t                           r_pc;
  rob_pkg::except_t [rob_conf_pkg::DISP_SIZE-1:0] r_except_type;
  rob_pkg::xlen_t   [rob_conf_pkg::DISP_SIZE-1:0] r_tval;
  logic [rob_conf_pkg::DONE_BUS_SIZE-1:0]   w_hit;

  // report addresses this entry
  always_comb begin
    for (int p = 0; p < rob_conf_pkg::DONE_BUS_SIZE; p++) begin
      w_hit[p] = i_done_rpt[p].valid & r_valid &
                 (i_done_rpt[p].cmt_id[rob_conf_pkg::ROB_ENTRY_W-1:0] ==
                  ENTRY_IDX[rob_conf_pkg::ROB_ENTRY_W-1:0]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_valid        <= 1'b0;
      r_grp_id       <= '0;
      r_done_grp_id  <= '0;
      r_br_upd       <= '0;
      r_except_valid <= '0;
    end else if (i_retire | i_flush) begin
      r_valid <= 1'b0;
    end else if (i_load) begin
      r_valid        <= 1'b1;
      r_grp_id       <= i_disp.grp_id;
      r_done_grp_id  <= '0;
      r_br_upd       <= '0;
      r_except_valid <= '0;
    end else begin
      for (int d = 0; d < rob_conf_pkg::DISP_SIZE; d++) begin
        for (int p = 0; p < rob_conf_pkg::DONE_BUS_SIZE; p++) begin
          if (w_hit[p] & i_done_rpt[p].grp_id[d]) begin
            r_done_grp_id[d] <= 1'b1;
            if (i_done_rpt[p].br_upd)       r_br_upd[d]       <= 1'b1;
            if (i_done_rpt[p].except_valid) r_except_valid[d] <= 1'b1;
          end
        end
      end
    end
  end

  // group pc and per-slot cause/tval
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_pc <= i_disp.pc;
    end
    for (int d = 0; d < rob_conf_pkg::DISP_SIZE; d++) begin
      for (int p = 0; p < rob_conf_pkg::DONE_BUS_SIZE; p++) begin
        if (w_hit[p] & i_done_rpt[p].grp_id[d] & i_done_rpt[p].except_valid) begin
          r_except_type[d] <= i_done_rpt[p].except_type;
          r_tval[d]        <= i_done_rpt[p].tval;
        end
      end
    end
  end

  assign o_entry.valid        = r_valid;
  assign o_entry.grp_id       = r_grp_id;
  assign o_entry.done_grp_id  = r_done_grp_id;
  assign o_entry.pc           = r_pc;
  assign o_entry.br_upd       = r_br_upd;
  assign o_entry.except_valid = r_except_valid;
  assign o_entry.except_type  = r_except_type;
  assign o_entry.tval         = r_tval;

  assign o_all_done = r_valid & (r_done_grp_id == r_grp_id);

endmodule

//--- hw/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
  input  rob_pkg::rob_entry_t                    i_entries [rob_conf_pkg::ROB_ENTRY_SIZE],
  input  logic [rob_conf_pkg::ROB_ENTRY_SIZE-1:0] i_all_done,
  input  rob_pkg::cmt_id_t                       i_out_id,
  output rob_pkg::commit_t                       o_commit,
  output logic [rob_conf_pkg::ROB_ENTRY_SIZE-1:0] o_retire,
  output logic                                   o_flush
);

  logic [rob_conf_pkg::ROB_ENTRY_W-1:0] w_head_idx;
  rob_pkg::rob_entry_t                  w_head;
  logic                                 w_commit;
  rob_pkg::grp_id_t                     w_upd;        // any redirecting slot
  rob_pkg::grp_id_t                     w_upd_oh;     // first one only
  rob_pkg::grp_id_t                     w_except_oh;
  rob_pkg::grp_id_t                     w_dead;
  rob_pkg::except_t                     w_except_type;
  rob_pkg::xlen_t                       w_tval;
  rob_pkg::xlen_t                       w_epc;

  // ------------------------------------------------------------------------
  // head selection
  // ------------------------------------------------------------------------
  assign w_head_idx = i_out_id[rob_conf_pkg::ROB_ENTRY_W-1:0];
  assign w_head     = i_entries[w_head_idx];
  assign w_commit   = i_all_done[w_head_idx];

  assign o_retire = {{(rob_conf_pkg::ROB_ENTRY_SIZE-1){1'b0}}, w_commit} << w_head_idx;

  // ------------------------------------------------------------------------
  // first redirect in the group, later slots are dead
  // ------------------------------------------------------------------------
  assign w_upd = w_head.br_upd | w_head.except_valid;

  always_comb begin : pick_blk
    logic seen;
    seen     = 1'b0;
    w_upd_oh = '0;
    w_dead   = '0;
    w_epc    = w_head.pc;    // no redirect, slot 0
    for (int d = 0; d < rob_conf_pkg::DISP_SIZE; d++) begin
      w_dead[d] = seen & w_head.grp_id[d];
      if (!seen && w_upd[d]) begin
        w_upd_oh[d] = 1'b1;
        w_epc       = w_head.pc + rob_pkg::xlen_t'(d * 4);
      end
      seen = seen | w_upd[d];
    end
  end

  // branch redirect leaves this empty
  assign w_except_oh = w_upd_oh & w_head.except_valid;

  // one-hot mux of cause and tval
  always_comb begin
    w_except_type = rob_pkg::INST_ADDR_MISALIGN;
    w_tval        = '0;
    for (int d = 0; d < rob_conf_pkg::DISP_SIZE; d++) begin
      if (w_except_oh[d]) begin
        w_except_type = w_head.except_type[d];
        w_tval        = w_head.tval[d];
      end
    end
  end

  assign o_commit.commit       = w_commit;
  assign o_commit.cmt_id       = i_out_id;
  assign o_commit.grp_id       = w_head.grp_id;
  assign o_commit.except_valid = w_except_oh;
  assign o_commit.except_type  = w_except_type;
  assign o_commit.tval         = w_tval;
  assign o_commit.epc          = w_epc;
  assign o_commit.dead_id      = w_dead;
  assign o_commit.flush        = w_commit & (|w_upd);

  assign o_flush = o_commit.flush;    // kills all younger groups

endmodule

//--- hw/rob_top.sv
`timescale 1ns/1ps

module rob_top (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  rob_pkg::disp_t     i_disp,
  input  rob_pkg::done_rpt_t i_done_rpt [rob_conf_pkg::DONE_BUS_SIZE],
  output logic               o_disp_ready,
  output rob_pkg::cmt_id_t   o_new_cmt_id,
  output rob_pkg::commit_t   o_commit
);

  rob_pkg::rob_entry_t                     w_entries [rob_conf_pkg::ROB_ENTRY_SIZE];
  logic [rob_conf_pkg::ROB_ENTRY_SIZE-1:0] w_all_done;
  logic [rob_conf_pkg::ROB_ENTRY_SIZE-1:0] w_retire;
  logic [rob_conf_pkg::ROB_ENTRY_SIZE-1:0] w_load_vec;   // per-entry load strobe
  rob_pkg::cmt_id_t                        w_in_id;
  rob_pkg::cmt_id_t                        w_out_id;
  logic                                    w_load;
  logic                                    w_flush;

  rob_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp.valid),
    .i_pop        (o_commit.commit),
    .i_flush      (w_flush),
    .o_disp_ready (o_disp_ready),
    .o_in_id      (w_in_id),
    .o_out_id     (w_out_id),
    .o_load       (w_load)
  );

  assign o_new_cmt_id = w_in_id;

  // route the load to the entry at the in pointer
  assign w_load_vec = {{(rob_conf_pkg::ROB_ENTRY_SIZE-1){1'b0}}, w_load} <<
                      w_in_id[rob_conf_pkg::ROB_ENTRY_W-1:0];

  for (genvar c_idx = 0; c_idx < rob_conf_pkg::ROB_ENTRY_SIZE; c_idx++) begin : g_entry
    rob_entry #(.ENTRY_IDX(c_idx)) u_entry (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_load     (w_load_vec[c_idx]),
      .i_disp     (i_disp),
      .i_done_rpt (i_done_rpt),
      .i_retire   (w_retire[c_idx]),
      .i_flush    (w_flush),
      .o_entry    (w_entries[c_idx]),
      .o_all_done (w_all_done[c_idx])
    );
  end

  rob_commit u_commit (
    .i_entries  (w_entries),
    .i_all_done (w_all_done),
    .i_out_id   (w_out_id),
    .o_commit   (o_commit),
    .o_retire   (w_retire),
    .o_flush    (w_flush)
  );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;    // 20 ns period
  end

  // reset is active high, held over the first three rising edges
  initial begin
    o_reset_n = 1'b1;
    repeat (3) @(posedge o_clk);
    o_reset_n <= 1'b0;
  end

endmodule

//--- verification/rob_properties.sv
`timescale 1ns/1ps

module rob_properties (
  input logic             i_clk,
  input logic             i_reset_n,
  input rob_pkg::commit_t i_commit,
  input logic             i_disp_ready,
  input rob_pkg::cmt_id_t i_in_id,
  input rob_pkg::cmt_id_t i_out_id
);

  rob_pkg::cmt_id_t w_held;        // groups in flight
  int               fail_cnt = 0;  // summed into the testbench error count

  assign w_held = i_in_id - i_out_id;

  // a dead slot must have been dispatched
  a_dead_in_grp : assert property (@(posedge i_clk) disable iff (i_reset_n)
    i_commit.commit |-> ((i_commit.dead_id & ~i_commit.grp_id) == '0))
  else begin
    fail_cnt++;
    $error("dead_id marks a slot outside grp_id");
  end

  a_one_except : assert property (@(posedge i_clk) disable iff (i_reset_n)
    $onehot0(i_commit.except_valid))
  else begin
    fail_cnt++;
    $error("except_valid has more than one bit set");
  end

  a_flush_commit : assert property (@(posedge i_clk) disable iff (i_reset_n)
    i_commit.flush |-> i_commit.commit)
  else begin
    fail_cnt++;
    $error("flush raised without a commit");
  end

  // every entry taken, nothing more may enter
  a_full_ready : assert property (@(posedge i_clk) disable iff (i_reset_n)
    (w_held == rob_pkg::cmt_id_t'(rob_conf_pkg::ROB_ENTRY_SIZE)) |-> !i_disp_ready)
  else begin
    fail_cnt++;
    $error("dispatch ready is high while the buffer is full");
  end

endmodule

//--- verification/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int PLANNED_GROUPS  = 23;
  localparam int WATCHDOG_CYCLES = PLANNED_GROUPS * 40 + 400;

  // one expected commit
  typedef struct packed {
    rob_pkg::cmt_id_t                            id;
    rob_pkg::grp_id_t                            grp;
    rob_pkg::xlen_t                              pc;
    logic [$clog2(rob_conf_pkg::DISP_SIZE)-1:0] slot;    // planned redirect slot
    logic                                        redir;
    logic                                        exc;     // set for exception, clear for branch
    rob_pkg::except_t                            cause;
    rob_pkg::xlen_t                              tval;
  } exp_t;

  logic               clk;
  logic               reset_n;
  rob_pkg::disp_t     disp;
  rob_pkg::done_rpt_t rpt [rob_conf_pkg::DONE_BUS_SIZE];
  logic               disp_ready;
  rob_pkg::cmt_id_t   new_cmt_id;
  rob_pkg::commit_t   commit;

  exp_t               exp_q[$];
  rob_pkg::done_rpt_t rpt_q[$];
  rob_pkg::cmt_id_t   next_id;
  int                 seed = 79;
  int                 err_cnt = 0;
  int                 n_commits = 0;
  int                 n_pass = 0;
  int                 n_fail = 0;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_reset_n(reset_n));

  rob_top UUT (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp       (disp),
    .i_done_rpt   (rpt),
    .o_disp_ready (disp_ready),
    .o_new_cmt_id (new_cmt_id),
    .o_commit     (commit)
  );

  bind rob_top rob_properties u_props (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (o_commit),
    .i_disp_ready (o_disp_ready),
    .i_in_id      (w_in_id),
    .i_out_id     (w_out_id)
  );

  // --------------------------------------------------------------------------
  // error bookkeeping
  // --------------------------------------------------------------------------
  task automatic fail_value(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    $display("Fail at %0t ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic note_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  function automatic int total_errors();
    return err_cnt + UUT.u_props.fail_cnt;
  endfunction

  task automatic finish_test(input string name, input int base);
    if (total_errors() == base) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, total_errors() - base);
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------
  function automatic rob_pkg::grp_id_t rand_grp();
    rob_pkg::grp_id_t g;
    g = rob_pkg::grp_id_t'($random(seed));
    return (g == '0) ? rob_pkg::grp_id_t'(1) : g;    // never empty
  endfunction

  function automatic exp_t plain_group(input rob_pkg::grp_id_t g, input rob_pkg::xlen_t pc);
    exp_t e;
    e     = '0;
    e.grp = g;
    e.pc  = pc & ~rob_pkg::xlen_t'(3);
    return e;
  endfunction

  task automatic dispatch_group(input exp_t e);
    int waited;
    waited = 0;
    @(posedge clk);
    disp <= '{valid: 1'b1, grp_id: e.grp, pc: e.pc};
    @(posedge clk);
    while (!disp_ready && waited < 100) begin
      waited++;
      @(posedge clk);
    end
    if (!disp_ready) begin
      note_error("dispatch was never accepted");
    end else begin
      assert (new_cmt_id == next_id) else fail_value("new_cmt_id", next_id, new_cmt_id);
      e.id = next_id;
      exp_q.push_back(e);
      next_id = next_id + 1'b1;
    end
    disp.valid <= 1'b0;
  endtask

  // one report per slot picked by mask with the redirect on the planned slot
  task automatic queue_reports(input exp_t e, input rob_pkg::grp_id_t mask);
    rob_pkg::done_rpt_t r;
    for (int d = 0; d < rob_conf_pkg::DISP_SIZE; d++) begin
      if (e.grp[d] & mask[d]) begin
        r              = '0;
        r.valid        = 1'b1;
        r.cmt_id       = e.id;
        r.grp_id[d]    = 1'b1;
        r.br_upd       = e.redir & ~e.exc & (e.slot == d);
        r.except_valid = e.redir & e.exc & (e.slot == d);
        r.except_type  = e.cause;
        r.tval         = e.tval;
        rpt_q.push_back(r);
      end
    end
  endtask

  task automatic shuffle_reports();
    rob_pkg::done_rpt_t tmp;
    int                 j;
    for (int i = rpt_q.size() - 1; i > 0; i--) begin
      j        = int'($unsigned($random(seed)) % (i + 1));
      tmp      = rpt_q[i];
      rpt_q[i] = rpt_q[j];
      rpt_q[j] = tmp;
    end
  endtask

  task automatic send_reports();
    while (rpt_q.size() != 0) begin
      @(posedge clk);
      for (int p = 0; p < rob_conf_pkg::DONE_BUS_SIZE; p++) begin
        if (rpt_q.size() != 0) begin
          rpt[p] <= rpt_q.pop_front();
        end else begin
          rpt[p] <= '0;
        end
      end
    end
    @(posedge clk);
    for (int p = 0; p < rob_conf_pkg::DONE_BUS_SIZE; p++) begin
      rpt[p] <= '0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 200) begin
      @(posedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else note_error("expected commits did not appear in time");
    @(posedge clk);
  endtask

  // --------------------------------------------------------------------------
  // compare each commit with the oldest expected group
  // --------------------------------------------------------------------------
  task automatic check_commit();
    exp_t             e;
    rob_pkg::grp_id_t dead;
    rob_pkg::grp_id_t exc_oh;
    int               slot;
    if (exp_q.size() == 0) begin
      note_error("a commit appeared with no group outstanding");
    end else begin
      e      = exp_q.pop_front();
      slot   = e.redir ? int'(e.slot) : 0;
      dead   = '0;
      exc_oh = e.exc ? rob_pkg::grp_id_t'(1 << slot) : '0;
      for (int d = slot + 1; d < rob_conf_pkg::DISP_SIZE; d++) begin
        dead[d] = e.redir & e.grp[d];    // valid slots after the redirect
      end
      assert (commit.cmt_id == e.id) else fail_value("cmt_id", e.id, commit.cmt_id);
      assert (commit.grp_id == e.grp) else fail_value("grp_id", e.grp, commit.grp_id);
      assert (commit.epc == e.pc + rob_pkg::xlen_t'(4 * slot))
        else fail_value("epc", e.pc + rob_pkg::xlen_t'(4 * slot), commit.epc);
      assert (commit.dead_id == dead) else fail_value("dead_id", dead, commit.dead_id);
      assert (commit.except_valid == exc_oh)
        else fail_value("except_valid", exc_oh, commit.except_valid);
      assert (commit.flush == e.redir) else fail_value("flush", e.redir, commit.flush);
      if (e.exc) begin
        assert (commit.except_type == e.cause)
          else fail_value("except_type", e.cause, commit.except_type);
        assert (commit.tval == e.tval) else fail_value("tval", e.tval, commit.tval);
      end
      if (e.redir) begin
        exp_q.delete();    // younger groups die with the flush
        next_id = e.id + 1'b1;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset_n && commit.commit) begin
      n_commits++;
      check_commit();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    exp_t e;
    exp_t first;
    int   n;
    int   base;
    disp    = '0;
    next_id = '0;
    for (int p = 0; p < rob_conf_pkg::DONE_BUS_SIZE; p++) begin
      rpt[p] = '0;
    end
    @(negedge reset_n);

    // in-order commit
    base = total_errors();
    @(negedge clk);
    assert (disp_ready && new_cmt_id == '0 && !commit.commit)
      else note_error("state after reset is wrong");
    for (int i = 0; i < 8; i++) begin
      dispatch_group(plain_group(rand_grp(), rob_pkg::xlen_t'($random(seed))));
    end
    foreach (exp_q[i]) begin
      queue_reports(exp_q[i], '1);
    end
    shuffle_reports();
    send_reports();
    wait_drain();
    finish_test("in-order commit", base);

    // completion gating with slot 2 of the oldest group held back
    base = total_errors();
    dispatch_group(plain_group(rand_grp() | 4'b0100, rob_pkg::xlen_t'($random(seed))));
    dispatch_group(plain_group(rand_grp(), rob_pkg::xlen_t'($random(seed))));
    first = exp_q[0];
    queue_reports(exp_q[0], 4'b1011);
    queue_reports(exp_q[1], '1);
    shuffle_reports();
    n = n_commits;
    send_reports();
    repeat (10) @(posedge clk);
    assert (n_commits == n) else note_error("a group committed with a report missing");
    queue_reports(first, 4'b0100);
    send_reports();
    wait_drain();
    finish_test("completion gating", base);

    // full buffer
    base = total_errors();
    for (int i = 0; i < rob_conf_pkg::ROB_ENTRY_SIZE; i++) begin
      dispatch_group(plain_group(rand_grp(), rob_pkg::xlen_t'($random(seed))));
    end
    @(posedge clk);
    disp <= '{valid: 1'b1, grp_id: 4'b0001, pc: 32'h0000_0100};
    repeat (4) begin
      @(posedge clk);
      assert (!disp_ready) else note_error("ready is high with a full buffer");
    end
    disp.valid <= 1'b0;
    assert (new_cmt_id == next_id) else fail_value("new_cmt_id", next_id, new_cmt_id);
    queue_reports(exp_q[0], '1);
    send_reports();
    n = 0;
    while (!disp_ready && n < 50) begin
      @(posedge clk);
      n++;
    end
    assert (disp_ready) else note_error("ready did not return after a commit");
    foreach (exp_q[i]) begin
      queue_reports(exp_q[i], '1);
    end
    shuffle_reports();
    send_reports();
    wait_drain();
    finish_test("full buffer", base);

    // exception commit where slot 1 wins over a later fault on slot 3
    base    = total_errors();
    e       = plain_group(4'b1011, 32'h0000_4000);
    e.redir = 1'b1;
    e.exc   = 1'b1;
    e.slot  = 1;
    e.cause = rob_pkg::ILLEGAL_INST;
    e.tval  = 32'h0bad_c0de;
    dispatch_group(e);
    queue_reports(exp_q[0], '1);
    foreach (rpt_q[i]) begin
      if (rpt_q[i].grp_id[3]) begin
        rpt_q[i].except_valid = 1'b1;
        rpt_q[i].except_type  = rob_pkg::LOAD_ACC_FAULT;
        rpt_q[i].tval         = 32'h0000_0044;
      end
    end
    shuffle_reports();
    send_reports();
    wait_drain();
    finish_test("exception commit", base);

    // branch flush where younger groups complete first and must never commit
    base    = total_errors();
    e       = plain_group(4'b1111, 32'h0000_8000);
    e.redir = 1'b1;
    e.slot  = 1;
    dispatch_group(e);
    dispatch_group(plain_group(rand_grp(), 32'h0000_8010));
    dispatch_group(plain_group(rand_grp(), 32'h0000_8020));
    queue_reports(exp_q[1], '1);
    queue_reports(exp_q[2], '1);
    shuffle_reports();
    send_reports();
    queue_reports(exp_q[0], '1);
    send_reports();
    wait_drain();
    n = n_commits;
    repeat (10) @(posedge clk);
    assert (n_commits == n) else note_error("a flushed group committed");
    dispatch_group(plain_group(rand_grp(), 32'h0000_9000));
    queue_reports(exp_q[0], '1);
    send_reports();
    wait_drain();
    finish_test("branch flush", base);

    $display("tests passed: %0d failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
hw/rob_conf_pkg.sv
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_entry.sv
hw/rob_commit.sv
hw/rob_top.sv
verification/tb_clk_gen.sv
verification/rob_properties.sv
verification/rob_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module rob_tb -Mdir obj_dir

./obj_dir/Vrob_tb +verilator+error+limit+1000 | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "result: failed"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "result: run ended without a verdict"
  exit 1
fi
echo "result: passed"
